/* include/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_WORD_W 16
`define CPU_QUEUE_DEPTH 4

// instruction length in stream words
`define INSTR_LEN_1 2'd1
`define INSTR_LEN_2 2'd2
`define INSTR_LEN_3 2'd3

`define OP_NOP  16'h0000
`define OP_SCF  16'h0001
`define OP_CFF  16'h0002
`define OP_COF  16'h0003
`define OP_CZF  16'h0004
`define OP_MOV3 16'h0007 // reg to reg
`define OP_MOV4 16'h0008 // immediate
`define OP_OUT  16'h000A
`define OP_XCH  16'h0029
`define OP_ADD  16'h000C
`define OP_ADC  16'h000D
`define OP_SUB  16'h000E
`define OP_SUC  16'h000F
`define OP_CMP  16'h0014
`define OP_AND  16'h0015
`define OP_NEG  16'h0016
`define OP_OR   16'h0018
`define OP_SHL  16'h0019
`define OP_SHR  16'h001A
`define OP_XOR  16'h001B
`define OP_TEST 16'h001C

`endif

/* hdl/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

	// general register select
	typedef enum logic [1:0] {
		regAx = 2'b00,
		regBx = 2'b01,
		regCx = 2'b10,
		regDx = 2'b11
	} regSel;

	typedef struct packed {
		logic [`CPU_WORD_W-5:0] pad; // unused upper bits
		regSel dst;                  // bits 3:2
		regSel src;                  // bits 1:0 hold the single-reg operand too
	} regPair;

	// par1 is either register fields or a plain value (SCF)
	typedef union packed {
		regPair regs;
		logic [`CPU_WORD_W-1:0] value;
	} operandWord;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] opcode;
		operandWord par1;
		logic [`CPU_WORD_W-1:0] par2; // immediate for MOV4
	} instr;

endpackage

/* hdl/instr_if.sv */
`timescale 1ns/100ps

interface instr_if;
	logic valid;
	logic ready;
	cpu_pkg::instr data; // opcode, par1, par2

	modport producer (
		output valid,
		output data,
		input  ready
	);

	modport consumer (
		input  valid,
		input  data,
		output ready
	);
endinterface

/* hdl/instr_assembler.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module instrAssembler (
	input  logic clk,
	input  logic reset,
	input  logic wordValid,
	output logic wordReady,
	input  logic [`CPU_WORD_W-1:0] wordData,
	instr_if.producer instrOut
);
	logic armed;
	logic [1:0] wordCnt;
	logic [1:0] lenReg;
	logic [1:0] curLen;
	logic [`CPU_WORD_W-1:0] opReg;
	logic [`CPU_WORD_W-1:0] par1Reg;
	logic accept;
	logic lastWord;
	logic validReg;
	cpu_pkg::instr dataReg;
	cpu_pkg::instr nextInstr;

	function automatic logic [1:0] instrLen(input logic [`CPU_WORD_W-1:0] op);
		case (op)
			`OP_NOP, `OP_CFF, `OP_COF, `OP_CZF, `OP_OUT: instrLen = `INSTR_LEN_1;
			`OP_MOV4: instrLen = `INSTR_LEN_3;
			`OP_SCF, `OP_MOV3, `OP_XCH, `OP_ADD, `OP_ADC, `OP_SUB, `OP_SUC,
			`OP_CMP, `OP_AND, `OP_NEG, `OP_OR, `OP_SHL, `OP_SHR, `OP_XOR,
			`OP_TEST: instrLen = `INSTR_LEN_2;
			default: instrLen = `INSTR_LEN_1; // unknown, treated as NOP
		endcase
	endfunction

	assign wordReady = armed & ~validReg; // hold off while queue is busy
	assign accept = wordValid & wordReady;
	assign curLen = (wordCnt == 2'd0) ? instrLen(wordData) : lenReg;
	assign lastWord = accept && ((wordCnt + 2'd1) == curLen);

	// instruction as it looks once the current word is added
	always_comb begin
		nextInstr.opcode = (wordCnt == 2'd0) ? wordData : opReg;
		if (wordCnt == 2'd1)
			nextInstr.par1.value = wordData;
		else if (wordCnt == 2'd0)
			nextInstr.par1.value = '0; // short instr, missing words are zero
		else
			nextInstr.par1.value = par1Reg;
		nextInstr.par2 = (wordCnt == 2'd2) ? wordData : '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			armed <= 1'b0;
			wordCnt <= 2'd0;
			validReg <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (validReg && instrOut.ready)
				validReg <= 1'b0;
			else if (lastWord)
				validReg <= 1'b1;
			if (lastWord)
				wordCnt <= 2'd0;
			else if (accept)
				wordCnt <= wordCnt + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && wordCnt == 2'd0) begin
			opReg <= wordData;
			lenReg <= curLen;
		end
		if (accept && wordCnt == 2'd1)
			par1Reg <= wordData;
		if (lastWord)
			dataReg <= nextInstr;
	end

	assign instrOut.valid = validReg;
	assign instrOut.data = dataReg;
endmodule

/* hdl/instr_queue.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module instrQueue #(
	parameter int DEPTH = `CPU_QUEUE_DEPTH
) (
	input  logic clk,
	input  logic reset,
	instr_if.consumer instrIn,
	instr_if.producer instrOutQ
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	cpu_pkg::instr mem [DEPTH];
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W-1:0] wrPtr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign instrIn.ready = (count != CNT_W'(DEPTH)); // low when full
	assign instrOutQ.valid = (count != '0);
	assign instrOutQ.data = mem[rdPtr];

	assign push = instrIn.valid & instrIn.ready;
	assign pop = instrOutQ.valid & instrOutQ.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither, level unchanged
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= instrIn.data;
	end
endmodule

/* hdl/exec_core.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module execCore (
	input  logic clk,
	input  logic reset,
	instr_if.consumer instrIn,
	output logic outValid,
	input  logic outReady,
	output logic [`CPU_WORD_W-1:0] outAddr,
	output logic [`CPU_WORD_W-1:0] outData
);
	logic [`CPU_WORD_W-1:0] regFile [4]; // ax, bx, cx, dx
	logic cf; // carry
	logic zf; // zero
	logic of; // overflow
	logic take;
	logic [`CPU_WORD_W-1:0] opcode;
	cpu_pkg::operandWord par1;
	logic [`CPU_WORD_W-1:0] par2;
	logic [`CPU_WORD_W-1:0] dstVal;
	logic [`CPU_WORD_W-1:0] srcVal;
	logic isSub;
	logic useCarry;
	logic cIn;
	logic [`CPU_WORD_W-1:0] aluB;
	logic [`CPU_WORD_W:0] aluSum;
	logic [`CPU_WORD_W-1:0] aluRes;
	logic aluCf;
	logic aluZf;
	logic aluOf;

	// stall while an OUT result is still waiting
	assign instrIn.ready = ~(outValid & ~outReady);
	assign take = instrIn.valid & instrIn.ready;

	assign opcode = instrIn.data.opcode;
	assign par1 = instrIn.data.par1;
	assign par2 = instrIn.data.par2;
	assign dstVal = regFile[par1.regs.dst];
	assign srcVal = regFile[par1.regs.src];

	// one adder for add and subtract, subtract as dst + ~src + 1
	always_comb begin
		isSub = (opcode == `OP_SUB) || (opcode == `OP_SUC) || (opcode == `OP_CMP);
		useCarry = (opcode == `OP_ADC) || (opcode == `OP_SUC);
		cIn = useCarry ? (cf ^ isSub) : isSub;
		aluB = isSub ? ~srcVal : srcVal;
		aluSum = {1'b0, dstVal} + {1'b0, aluB} + {{`CPU_WORD_W{1'b0}}, cIn};
		aluRes = aluSum[`CPU_WORD_W-1:0];
		aluCf = aluSum[`CPU_WORD_W] ^ isSub; // borrow on subtract
		aluZf = (aluRes == '0);
		aluOf = (dstVal[`CPU_WORD_W-1] == aluB[`CPU_WORD_W-1]) &&
			(aluRes[`CPU_WORD_W-1] != dstVal[`CPU_WORD_W-1]);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 4; i++)
				regFile[i] <= '0;
			cf <= 1'b0;
			zf <= 1'b0;
			of <= 1'b0;
			outValid <= 1'b0;
		end else begin
			if (outValid && outReady)
				outValid <= 1'b0;
			if (take) begin
				case (opcode)
					`OP_NOP: ;
					`OP_SCF: cf <= par1.value[0];
					`OP_CFF: regFile[cpu_pkg::regDx] <= {{(`CPU_WORD_W-1){1'b0}}, cf};
					`OP_COF: regFile[cpu_pkg::regDx] <= {{(`CPU_WORD_W-1){1'b0}}, of};
					`OP_CZF: regFile[cpu_pkg::regDx] <= {{(`CPU_WORD_W-1){1'b0}}, zf};
					`OP_MOV3: regFile[par1.regs.dst] <= srcVal; // same reg is a no-op
					`OP_MOV4: regFile[par1.regs.src] <= par2;
					`OP_XCH: begin
						regFile[par1.regs.dst] <= srcVal;
						regFile[par1.regs.src] <= dstVal;
					end
					`OP_OUT: begin
						outAddr <= regFile[cpu_pkg::regBx];
						outData <= regFile[cpu_pkg::regDx];
						outValid <= 1'b1;
					end
					`OP_ADD, `OP_ADC, `OP_SUB, `OP_SUC: begin
						regFile[par1.regs.dst] <= aluRes;
						cf <= aluCf;
						zf <= aluZf;
						of <= aluOf;
					end
					`OP_CMP: begin // flags only
						cf <= aluCf;
						zf <= aluZf;
						of <= aluOf;
					end
					`OP_AND: regFile[par1.regs.dst] <= dstVal & srcVal;
					`OP_OR: regFile[par1.regs.dst] <= dstVal | srcVal;
					`OP_XOR: regFile[par1.regs.dst] <= dstVal ^ srcVal;
					`OP_NEG: regFile[par1.regs.src] <= ~srcVal;
					`OP_SHL: regFile[par1.regs.src] <= srcVal << 1;
					`OP_SHR: regFile[par1.regs.src] <= srcVal >> 1;
					`OP_TEST: zf <= (dstVal == srcVal);
					default: ; // unknown opcode, nothing changes
				endcase
			end
		end
	end
endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpuTop (
	input  logic clk,
	input  logic reset,
	input  logic wordValid,
	output logic wordReady,
	input  logic [`CPU_WORD_W-1:0] wordData,
	output logic outValid,
	input  logic outReady,
	output logic [`CPU_WORD_W-1:0] outAddr,
	output logic [`CPU_WORD_W-1:0] outData
);
	instr_if asmToQueue ();
	instr_if queueToCore ();

	instrAssembler uAssembler (
		.clk      (clk),
		.reset    (reset),
		.wordValid(wordValid),
		.wordReady(wordReady),
		.wordData (wordData),
		.instrOut (asmToQueue)
	);

	instrQueue #(
		.DEPTH(`CPU_QUEUE_DEPTH)
	) uQueue (
		.clk      (clk),
		.reset    (reset),
		.instrIn  (asmToQueue),
		.instrOutQ(queueToCore)
	);

	execCore uCore (
		.clk     (clk),
		.reset   (reset),
		.instrIn (queueToCore),
		.outValid(outValid),
		.outReady(outReady),
		.outAddr (outAddr),
		.outData (outData)
	);
endmodule

/* dv/cpu_asserts.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpuAsserts (
	input logic clk,
	input logic reset,
	input logic wordReady,
	input logic outValid,
	input logic outReady,
	input logic [`CPU_WORD_W-1:0] outAddr,
	input logic [`CPU_WORD_W-1:0] outData
);
	// a stalled result must neither move nor vanish
	outHoldsWhileStalled: assert property (@(posedge clk) disable iff (reset)
		(outValid && !outReady) |=> (outValid && $stable(outAddr) && $stable(outData)))
		else $error("output changed while outReady was low");

	resetQuiet: assert property (@(posedge clk) reset |=> (!wordReady && !outValid))
		else $error("wordReady or outValid high during reset");
endmodule

bind cpuTop cpuAsserts uAsserts (
	.clk      (clk),
	.reset    (reset),
	.wordReady(wordReady),
	.outValid (outValid),
	.outReady (outReady),
	.outAddr  (outAddr),
	.outData  (outData)
);

/* dv/cpu_checker.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpuChecker (
	input  logic clk,
	input  logic reset,
	input  logic wordValid,
	input  logic wordReady,
	input  logic [`CPU_WORD_W-1:0] wordData,
	input  logic outValid,
	input  logic outReady,
	input  logic [`CPU_WORD_W-1:0] outAddr,
	input  logic [`CPU_WORD_W-1:0] outData,
	input  logic endOfRun,
	output int errCount,
	output int pendingOuts
);
	logic [15:0] regs [4]; // model of ax, bx, cx, dx
	logic cf;
	logic zf;
	logic of;
	logic [15:0] words [3]; // words of the instruction being gathered
	int wordCnt;
	logic [31:0] expQ [$]; // {bx, dx} per OUT
	logic [31:0] expPair;
	int compared;
	int blockedRun;
	bit blockedSeen;
	bit reported;

	function automatic int wordsInInstr(input logic [15:0] op);
		case (op)
			`OP_MOV4: return 3;
			`OP_SCF, `OP_MOV3, `OP_XCH, `OP_ADD, `OP_ADC, `OP_SUB, `OP_SUC, `OP_CMP,
			`OP_AND, `OP_OR, `OP_XOR, `OP_NEG, `OP_SHL, `OP_SHR, `OP_TEST: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic void applyInstr(input logic [15:0] op, input logic [15:0] p1,
			input logic [15:0] p2);
		logic [1:0] d;
		logic [1:0] s;
		logic [15:0] a;
		logic [15:0] b;
		logic [16:0] wide;
		int sRes;
		d = p1[3:2];
		s = p1[1:0];
		a = regs[d];
		b = regs[s];
		case (op)
			`OP_SCF: cf = p1[0];
			`OP_CFF: regs[3] = {15'd0, cf};
			`OP_COF: regs[3] = {15'd0, of};
			`OP_CZF: regs[3] = {15'd0, zf};
			`OP_MOV3: regs[d] = b;
			`OP_MOV4: regs[s] = p2;
			`OP_XCH: begin
				regs[d] = b;
				regs[s] = a;
			end
			`OP_OUT: expQ.push_back({regs[1], regs[3]});
			`OP_ADD, `OP_ADC: begin
				wide = {1'b0, a} + {1'b0, b} + {16'd0, (op == `OP_ADC) & cf};
				sRes = int'($signed(a)) + int'($signed(b)) + int'((op == `OP_ADC) & cf);
				of = (sRes > 32767) || (sRes < -32768); // signed result out of range
				regs[d] = wide[15:0];
				cf = wide[16];
				zf = (wide[15:0] == 16'd0);
			end
			`OP_SUB, `OP_SUC, `OP_CMP: begin
				wide = {1'b0, a} - {1'b0, b} - {16'd0, (op == `OP_SUC) & cf};
				sRes = int'($signed(a)) - int'($signed(b)) - int'((op == `OP_SUC) & cf);
				of = (sRes > 32767) || (sRes < -32768);
				if (op != `OP_CMP)
					regs[d] = wide[15:0];
				cf = wide[16]; // borrow
				zf = (wide[15:0] == 16'd0);
			end
			`OP_AND: regs[d] = a & b;
			`OP_OR: regs[d] = a | b;
			`OP_XOR: regs[d] = a ^ b;
			`OP_NEG: regs[s] = ~b;
			`OP_SHL: regs[s] = {b[14:0], 1'b0};
			`OP_SHR: regs[s] = {1'b0, b[15:1]};
			`OP_TEST: zf = (a == b);
			default: ; // NOP and unknown opcodes
		endcase
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 4; i++)
				regs[i] = '0;
			cf = 1'b0;
			zf = 1'b0;
			of = 1'b0;
			wordCnt = 0;
			expQ.delete();
			errCount = 0;
			compared = 0;
			blockedRun = 0;
			blockedSeen = 1'b0;
			reported = 1'b0;
		end else begin
			if (wordValid && wordReady) begin
				words[wordCnt] = wordData;
				wordCnt++;
				if (wordCnt == wordsInInstr(words[0])) begin
					applyInstr(words[0], (wordCnt > 1) ? words[1] : 16'd0,
						(wordCnt > 2) ? words[2] : 16'd0);
					wordCnt = 0;
				end
			end
			if (outValid && outReady) begin
				if (expQ.size() == 0) begin
					$display("output at %0t ns came with no OUT instruction left to match",
						$time);
					errCount++;
				end else begin
					expPair = expQ.pop_front();
					compared++;
					if (outAddr !== expPair[31:16]) begin
						$display("FAIL %0t ns outAddr got %h expected %h", $time,
							outAddr, expPair[31:16]);
						errCount++;
					end
					if (outData !== expPair[15:0]) begin
						$display("FAIL %0t ns outData got %h expected %h", $time,
							outData, expPair[15:0]);
						errCount++;
					end
				end
			end
			// input held off for a while during an output stall
			blockedRun = (outValid && !outReady && wordValid && !wordReady) ?
				blockedRun + 1 : 0;
			if (blockedRun >= 8)
				blockedSeen = 1'b1;
			if (endOfRun && !reported) begin
				reported = 1'b1;
				if (expQ.size() != 0) begin
					$display("%0d expected outputs never appeared", expQ.size());
					errCount += expQ.size();
				end
				if (!blockedSeen) begin
					$display("wordReady never stayed low during a long output stall");
					errCount++;
				end
				$display("checker summary %0d outputs compared, %0d errors", compared, errCount);
			end
		end
		pendingOuts = expQ.size();
	end
endmodule

/* dv/tb_top.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module tbTop;
	localparam int WAIT_LIMIT = 2000; // cycles before a wait gives up

	logic clk;
	logic reset;
	logic wordValid;
	logic wordReady;
	logic [`CPU_WORD_W-1:0] wordData;
	logic outValid;
	logic outReady;
	logic [`CPU_WORD_W-1:0] outAddr;
	logic [`CPU_WORD_W-1:0] outData;
	logic endOfRun;
	int errCount;
	int pendingOuts;
	int stallMode; // 0 always ready, 1 random, 2 long stalls
	int stallLeft;

	cpuTop u_dut (
		.clk      (clk),
		.reset    (reset),
		.wordValid(wordValid),
		.wordReady(wordReady),
		.wordData (wordData),
		.outValid (outValid),
		.outReady (outReady),
		.outAddr  (outAddr),
		.outData  (outData)
	);

	cpuChecker uChecker (
		.clk        (clk),
		.reset      (reset),
		.wordValid  (wordValid),
		.wordReady  (wordReady),
		.wordData   (wordData),
		.outValid   (outValid),
		.outReady   (outReady),
		.outAddr    (outAddr),
		.outData    (outData),
		.endOfRun   (endOfRun),
		.errCount   (errCount),
		.pendingOuts(pendingOuts)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// par1 with random padding above the register fields
	function automatic logic [15:0] regArgs(input int dst, input int src);
		return {12'($urandom), 2'(dst), 2'(src)};
	endfunction

	function automatic logic [15:0] aluOp(input int unsigned k);
		case (k % 12)
			0: return `OP_ADD;
			1: return `OP_ADC;
			2: return `OP_SUB;
			3: return `OP_SUC;
			4: return `OP_CMP;
			5: return `OP_AND;
			6: return `OP_OR;
			7: return `OP_XOR;
			8: return `OP_NEG;
			9: return `OP_SHL;
			10: return `OP_SHR;
			default: return `OP_TEST;
		endcase
	endfunction

	task automatic stopOnTimeout(input string what);
		$display("timeout: %s for %0d cycles", what, WAIT_LIMIT);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic sendWord(input logic [15:0] w);
		int waited;
		int gap;
		waited = 0;
		wordData = w;
		wordValid = 1'b1;
		while (!wordReady && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!wordReady)
			stopOnTimeout("wordReady stayed low");
		else begin
			@(posedge clk); // word taken here
			#1;
			wordValid = 1'b0;
			if ($urandom % 4 == 0) begin
				gap = 1 + int'($urandom % 3);
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
			end
		end
	endtask

	task automatic sendInstr(input logic [15:0] op, input logic [15:0] p1,
			input logic [15:0] p2, input int nWords);
		sendWord(op);
		if (nWords > 1)
			sendWord(p1);
		if (nWords > 2)
			sendWord(p2);
	endtask

	task automatic randomStep();
		int pick;
		pick = int'($urandom % 12);
		case (pick)
			0: sendInstr(`OP_MOV4, regArgs(0, $urandom % 4), 16'($urandom), 3);
			1: sendInstr(`OP_MOV3, regArgs($urandom % 4, $urandom % 4), 16'd0, 2);
			2: sendInstr(`OP_XCH, regArgs($urandom % 4, $urandom % 4), 16'd0, 2);
			3: sendInstr(`OP_SCF, 16'($urandom), 16'd0, 2);
			4: sendInstr(`OP_CFF, 16'd0, 16'd0, 1);
			5: sendInstr(`OP_COF, 16'd0, 16'd0, 1);
			6: sendInstr(`OP_CZF, 16'd0, 16'd0, 1);
			7: sendInstr(($urandom % 2) ? {1'b1, 15'($urandom)} : `OP_NOP, 16'd0, 16'd0, 1);
			11: sendInstr(`OP_OUT, 16'd0, 16'd0, 1);
			default: sendInstr(aluOp($urandom), regArgs($urandom % 4, $urandom % 4), 16'd0, 2);
		endcase
	endtask

	// output back-pressure
	always @(posedge clk) begin
		#1;
		if (stallMode == 0)
			outReady = 1'b1;
		else if (stallMode == 1)
			outReady = 1'($urandom % 2);
		else if (stallLeft > 0) begin
			stallLeft--;
			outReady = 1'b0;
		end else begin
			outReady = 1'b1;
			if ($urandom % 6 == 0)
				stallLeft = 20 + int'($urandom % 40);
		end
	end

	initial begin
		int waited;
		int d;
		void'($urandom(69103));
		reset = 1'b1;
		wordValid = 1'b0;
		wordData = '0;
		outReady = 1'b0;
		endOfRun = 1'b0;
		stallMode = 0;
		stallLeft = 0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// immediates, moves and swaps
		for (int r = 0; r < 4; r++)
			sendInstr(`OP_MOV4, regArgs(0, r), 16'($urandom), 3);
		for (int r = 0; r < 4; r++) begin
			sendInstr(`OP_MOV3, regArgs(1, r), 16'd0, 2);
			sendInstr(`OP_MOV3, regArgs(3, 3 - r), 16'd0, 2);
			sendInstr(`OP_OUT, 16'd0, 16'd0, 1);
			sendInstr(`OP_XCH, regArgs(1, 3), 16'd0, 2);
			sendInstr(`OP_OUT, 16'd0, 16'd0, 1);
		end

		// arithmetic and logic, flags read back through dx
		stallMode = 1;
		repeat (60) begin
			d = int'($urandom % 4);
			sendInstr(`OP_MOV4, regArgs(0, d), 16'($urandom), 3);
			sendInstr(`OP_MOV4, regArgs(0, $urandom % 4), 16'($urandom), 3);
			if ($urandom % 3 == 0)
				sendInstr(`OP_SCF, 16'($urandom), 16'd0, 2);
			sendInstr(aluOp($urandom), regArgs(d, $urandom % 4), 16'd0, 2);
			sendInstr(`OP_MOV3, regArgs(1, d), 16'd0, 2);
			sendInstr(`OP_OUT, 16'd0, 16'd0, 1);
			sendInstr(`OP_CFF, 16'd0, 16'd0, 1);
			sendInstr(`OP_OUT, 16'd0, 16'd0, 1);
			sendInstr(`OP_COF, 16'd0, 16'd0, 1);
			sendInstr(`OP_OUT, 16'd0, 16'd0, 1);
			sendInstr(`OP_CZF, 16'd0, 16'd0, 1);
			sendInstr(`OP_OUT, 16'd0, 16'd0, 1);
		end

		// unknown opcodes and NOP followed by real work
		repeat (10) begin
			sendInstr({1'b1, 15'($urandom)}, 16'd0, 16'd0, 1);
			sendInstr(`OP_NOP, 16'd0, 16'd0, 1);
			sendInstr(`OP_MOV4, regArgs(0, 3), 16'($urandom), 3);
			sendInstr(`OP_OUT, 16'd0, 16'd0, 1);
		end

		// random program under long output stalls
		stallMode = 2;
		repeat (300) randomStep();
		sendInstr(`OP_OUT, 16'd0, 16'd0, 1);
		stallMode = 0;

		waited = 0;
		while (pendingOuts != 0 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (pendingOuts != 0)
			stopOnTimeout("expected outputs did not arrive");
		else begin
			repeat (10) @(posedge clk); // room for any stray output
			#1;
			endOfRun = 1'b1;
			@(posedge clk);
			#1;
			if (errCount == 0)
				$display("TB PASSED");
			else
				$display("TB FAILED");
			$finish;
		end
	end
endmodule

/* streamCpu.f */
+incdir+include
hdl/cpu_pkg.sv
hdl/instr_if.sv
hdl/instr_assembler.sv
hdl/instr_queue.sv
hdl/exec_core.sv
hdl/cpu_top.sv
dv/cpu_asserts.sv
dv/cpu_checker.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# builds and runs the streamCpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbTop -f streamCpu.f -o simStreamCpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/simStreamCpu 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
echo "simulation did not report a pass"
exit 1
